// ==== memoryInterface.f ====
+incdir+src
src/memBusPkg.sv
src/memCorePkg.sv
src/axilMemFrontend.sv
src/memAddrReg.sv
src/sramArray.sv
src/memDataReg.sv
src/memoryInterface.sv
verif/memoryInterfaceTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the memory subsystem testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module memoryInterfaceTb \
	-f memoryInterface.f -o memTbSim || { echo "build failed"; exit 1; }

# the run counts as passed only when the testbench printed its pass line
simOut=$(./obj_dir/memTbSim 2>&1)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -q "Regression passed" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== src/axilMemFrontend.sv ====
// axilMemFrontend is the AXI4-Lite slave that turns bus transfers into memory requests
`timescale 1ns/1ps
`include "memSettings.svh"

module axilMemFrontend (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 awValid,
	output logic                 awReady,
	input  memBusPkg::axiAw      aw,
	input  logic                 wValid,
	output logic                 wReady,
	input  memBusPkg::axiW       w,
	output logic                 bValid,
	input  logic                 bReady,
	output memBusPkg::axiB       b,
	input  logic                 arValid,
	output logic                 arReady,
	input  memBusPkg::axiAr      ar,
	output logic                 rValid,
	input  logic                 rReady,
	output memBusPkg::axiR       r,
	output logic                 reqValid,
	input  logic                 reqReady,
	output memCorePkg::memReq    req,
	input  logic                 resValid,
	output logic                 resReady,
	input  memCorePkg::memResult res
);

	logic writePending;
	logic readPending;
	logic selWrite;
	logic lastWasWrite;
	logic resIsWrite;

	// a write is only complete once both its address and its data are offered
	assign writePending = awValid && wValid;
	assign readPending = arValid;

	// writes win unless a read is also waiting and the last served request was a write
	assign selWrite = writePending && (!readPending || !lastWasWrite);

	// the request valid never looks at the MAR ready
	assign reqValid = writePending || readPending;

	// AW and W are taken together in the same cycle
	assign awReady = selWrite && reqReady;
	assign wReady = selWrite && reqReady;
	assign arReady = !selWrite && readPending && reqReady;

	// build the request from whichever channel is being served
	always_comb begin
		if (selWrite) begin
			req.op = memCorePkg::MEM_WRITE;
			req.addr = aw.addr;
			req.wdata = w.data[`MEM_DATA_WIDTH-1:0];
			// only the strobes of the two stored byte lanes matter
			req.be = w.strb[`MEM_DATA_WIDTH/8-1:0];
		end else begin
			req.op = memCorePkg::MEM_READ;
			req.addr = ar.addr;
			req.wdata = '0;
			req.be = '0;
		end
	end

	// remember what went into the pipeline last so the other type goes next time
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			lastWasWrite <= 1'b0;
		end else if (reqValid && reqReady) begin
			lastWasWrite <= selWrite;
		end
	end

	// results come back in request order, the op picks the response channel
	assign resIsWrite = (res.op == memCorePkg::MEM_WRITE);
	assign bValid = resValid && resIsWrite;
	assign rValid = resValid && !resIsWrite;

	// the MDR only lets go of its item when the matching channel takes it
	assign resReady = resIsWrite ? bReady : rReady;

	// the error flag from the MAR becomes SLVERR on both channels
	always_comb begin
		if (res.err) begin
			b.resp = memBusPkg::RESP_SLVERR;
			r.resp = memBusPkg::RESP_SLVERR;
		end else begin
			b.resp = memBusPkg::RESP_OKAY;
			r.resp = memBusPkg::RESP_OKAY;
		end
		// stored data fills the low half, the upper lanes read as zero
		r.data = {{(`AXI_DATA_WIDTH - `MEM_DATA_WIDTH){1'b0}}, res.rdata};
	end

endmodule

// ==== src/memAddrReg.sv ====
// memAddrReg is the MAR stage that latches a request and decodes its word index
`timescale 1ns/1ps
`include "memSettings.svh"

module memAddrReg (
	input  logic               clk,
	input  logic               arstN,
	input  logic               inValid,
	output logic               inReady,
	input  memCorePkg::memReq  inReq,
	output logic               outValid,
	input  logic               outReady,
	output memCorePkg::sramReq outReq
);

	logic full;
	logic load;
	logic addrErr;
	memCorePkg::sramReq held;

	// the stage can take a new item when empty or when its item leaves now
	assign inReady = !full || outReady;
	assign load = inValid && inReady;

	// any byte address bit above the stored window points outside the array
	assign addrErr = |inReq.addr[`AXI_ADDR_WIDTH-1:`MEM_ADDR_WIDTH+2];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
		end else if (inReady) begin
			full <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			held.op <= inReq.op;
			// bits 1:0 select a byte inside the word and are dropped
			held.index <= inReq.addr[`MEM_ADDR_WIDTH+1:2];
			held.wdata <= inReq.wdata;
			// an errored request carries no byte enables so the array stays untouched
			held.be <= addrErr ? '0 : inReq.be;
			held.err <= addrErr;
		end
	end

	assign outValid = full;
	assign outReq = held;

endmodule

// ==== src/memBusPkg.sv ====
// memBusPkg holds the AXI4-Lite channel payloads and response codes of the external bus
`include "memSettings.svh"

package memBusPkg;

	// only two codes are ever produced by this slave
	// SLVERR flags an address outside the stored range
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axiResp;

	// write address channel payload
	// prot is accepted and ignored by the memory
	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [2:0]                 prot;
	} axiAw;

	// write data channel payload, one strobe bit per byte lane
	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0]   data;
		logic [`AXI_DATA_WIDTH/8-1:0] strb;
	} axiW;

	// write response channel payload
	typedef struct packed {
		axiResp resp;
	} axiB;

	// read address channel payload
	typedef struct packed {
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [2:0]                 prot;
	} axiAr;

	// read data channel payload
	// data is zero extended from the stored width
	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		axiResp                     resp;
	} axiR;

endpackage

// ==== src/memCorePkg.sv ====
// memCorePkg holds the items that travel between the internal memory pipeline stages
`include "memSettings.svh"

package memCorePkg;

	// direction of one memory access
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} memOp;

	// request from the bus front end into the MAR, still carrying the byte address
	typedef struct packed {
		memOp                         op;
		logic [`AXI_ADDR_WIDTH-1:0]   addr;
		logic [`MEM_DATA_WIDTH-1:0]   wdata;
		logic [`MEM_DATA_WIDTH/8-1:0] be;
	} memReq;

	// request from the MAR into the array, decoded to a word index
	// err marks an out of range address that must not touch the array
	typedef struct packed {
		memOp                         op;
		logic [`MEM_ADDR_WIDTH-1:0]   index;
		logic [`MEM_DATA_WIDTH-1:0]   wdata;
		logic [`MEM_DATA_WIDTH/8-1:0] be;
		logic                         err;
	} sramReq;

	// finished access, passed from the array to the MDR and on to the bus
	typedef struct packed {
		memOp                       op;
		logic [`MEM_DATA_WIDTH-1:0] rdata;
		logic                       err;
	} memResult;

endpackage

// ==== src/memDataReg.sv ====
// memDataReg is the MDR stage that keeps a finished result until the bus takes it
`timescale 1ns/1ps
`include "memSettings.svh"

module memDataReg (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 inValid,
	output logic                 inReady,
	input  memCorePkg::memResult inRes,
	output logic                 outValid,
	input  logic                 outReady,
	output memCorePkg::memResult outRes
);

	logic full;
	logic load;
	logic leaving;
	memCorePkg::memResult held;

	// a result leaves on the B or R handshake driven by the front end
	assign leaving = full && outReady;

	// empty or leaving, so a stalled bus backs up into the array stage
	assign inReady = !full || leaving;
	assign load = inValid && inReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (leaving) begin
			full <= 1'b0;
		end
	end

	// payload only moves on a load, it sits still for the whole stall
	always_ff @(posedge clk) begin
		if (load) begin
			held.op <= inRes.op;
			// read data stays zero extended at the bus, here it keeps the stored width
			held.rdata <= inRes.rdata;
			held.err <= inRes.err;
		end
	end

	assign outValid = full;
	assign outRes = held;

	// the bus side sees the same item until the handshake
	// no bypass from the array, so results always take this extra cycle

endmodule

// ==== src/memSettings.svh ====
// memory subsystem settings for word depth, stored width and AXI4-Lite bus widths
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// width of the word index that selects one SRAM row
`define MEM_ADDR_WIDTH 11

// only the low half of each bus word is kept in the array
`define MEM_DATA_WIDTH 16

// number of stored words, matches 2**MEM_ADDR_WIDTH
`define MEM_DEPTH 2048

// byte address width seen on the AXI4-Lite bus
`define AXI_ADDR_WIDTH 32

// data width of the AXI4-Lite bus, upper read bits come back as zero
`define AXI_DATA_WIDTH 32

`endif

// ==== src/memoryInterface.sv ====
// memoryInterface is the top of the memory subsystem, front end then MAR, SRAM and MDR
`timescale 1ns/1ps
`include "memSettings.svh"

module memoryInterface (
	input  logic            clk,
	input  logic            arstN,
	input  logic            awValid,
	output logic            awReady,
	input  memBusPkg::axiAw aw,
	input  logic            wValid,
	output logic            wReady,
	input  memBusPkg::axiW  w,
	output logic            bValid,
	input  logic            bReady,
	output memBusPkg::axiB  b,
	input  logic            arValid,
	output logic            arReady,
	input  memBusPkg::axiAr ar,
	output logic            rValid,
	input  logic            rReady,
	output memBusPkg::axiR  r
);

	// front end to MAR
	logic marValid;
	logic marReady;
	memCorePkg::memReq marReq;

	// MAR to array
	logic sramValid;
	logic sramReady;
	memCorePkg::sramReq sramIn;

	// array to MDR
	logic mdrValid;
	logic mdrReady;
	memCorePkg::memResult mdrIn;

	// MDR back to the front end
	logic resValid;
	logic resReady;
	memCorePkg::memResult res;

	axilMemFrontend uFrontend (
		.clk(clk), .arstN(arstN),
		.awValid(awValid), .awReady(awReady), .aw(aw),
		.wValid(wValid), .wReady(wReady), .w(w),
		.bValid(bValid), .bReady(bReady), .b(b),
		.arValid(arValid), .arReady(arReady), .ar(ar),
		.rValid(rValid), .rReady(rReady), .r(r),
		.reqValid(marValid), .reqReady(marReady), .req(marReq),
		.resValid(resValid), .resReady(resReady), .res(res)
	);

	memAddrReg uMar (
		.clk(clk), .arstN(arstN),
		.inValid(marValid), .inReady(marReady), .inReq(marReq),
		.outValid(sramValid), .outReady(sramReady), .outReq(sramIn)
	);

	sramArray uSram (
		.clk(clk), .arstN(arstN),
		.inValid(sramValid), .inReady(sramReady), .inReq(sramIn),
		.outValid(mdrValid), .outReady(mdrReady), .outRes(mdrIn)
	);

	memDataReg uMdr (
		.clk(clk), .arstN(arstN),
		.inValid(mdrValid), .inReady(mdrReady), .inRes(mdrIn),
		.outValid(resValid), .outReady(resReady), .outRes(res)
	);

endmodule

// ==== src/sramArray.sv ====
// sramArray is the synchronous word store with byte lane writes and a registered read
`timescale 1ns/1ps
`include "memSettings.svh"

module sramArray (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 inValid,
	output logic                 inReady,
	input  memCorePkg::sramReq   inReq,
	output logic                 outValid,
	input  logic                 outReady,
	output memCorePkg::memResult outRes
);

	logic [`MEM_DATA_WIDTH-1:0] mem [`MEM_DEPTH];
	logic full;
	logic load;
	logic isWrite;
	logic isRead;
	memCorePkg::memResult held;

	assign inReady = !full || outReady;
	assign load = inValid && inReady;

	// only accesses with a good address reach the array
	assign isWrite = (inReq.op == memCorePkg::MEM_WRITE) && !inReq.err;
	assign isRead = (inReq.op == memCorePkg::MEM_READ) && !inReq.err;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
		end else if (inReady) begin
			full <= inValid;
		end
	end

	// the write lands on the same edge that loads the stage
	// read data is captured on that edge too and held while the MDR is full
	always_ff @(posedge clk) begin
		if (load) begin
			for (int lane = 0; lane < `MEM_DATA_WIDTH / 8; lane++) begin
				if (isWrite && inReq.be[lane]) begin
					mem[inReq.index][lane*8 +: 8] <= inReq.wdata[lane*8 +: 8];
				end
			end
			held.op <= inReq.op;
			held.err <= inReq.err;
			held.rdata <= isRead ? mem[inReq.index] : '0;
		end
	end

	assign outValid = full;
	assign outRes = held;

endmodule

// ==== verif/memStimulus.txt ====
# columns: op (1 write, 0 read) addr wdata strb expResp expRdata, all in hex
# expResp 0 is OKAY and 2 is SLVERR, expRdata is the full 32-bit read word
1 00000000 5a5a1234 f 0 00000000
1 00001ffc a5a5beef f 0 00000000
1 00000004 00000001 f 0 00000000
1 00000400 ffffcafe f 0 00000000
1 00000ff8 00007e57 3 0 00000000
0 00000000 00000000 0 0 00001234
0 00001ffc 00000000 0 0 0000beef
0 00000004 00000000 0 0 00000001
0 00000400 00000000 0 0 0000cafe
0 00000ff8 00000000 0 0 00007e57
# byte lanes on word 4
1 00000010 00001357 f 0 00000000
1 00000010 0000ffaa 1 0 00000000
0 00000010 00000000 0 0 000013aa
1 00000010 000066ff 2 0 00000000
0 00000010 00000000 0 0 000066aa
1 00000010 00001111 c 0 00000000
0 00000010 00000000 0 0 000066aa
# out of range, the aliased words must stay as they were
1 00002000 00009999 f 2 00000000
0 00002000 00000000 0 2 00000000
0 00000000 00000000 0 0 00001234
1 80000004 0000eeee f 2 00000000
0 00000004 00000000 0 0 00000001
0 fffffffc 00000000 0 2 00000000
# byte offsets inside a word are dropped
1 00000023 0000d00d f 0 00000000
0 00000020 00000000 0 0 0000d00d
0 00000022 00000000 0 0 0000d00d
1 00000102 00004242 f 0 00000000
0 00000100 00000000 0 0 00004242
0 00001ffc 00000000 0 0 0000beef

// ==== verif/memoryInterfaceTb.sv ====
// testbench for the AXI4-Lite memory subsystem, replays the stimulus file and checks every response
`timescale 1ns/1ps
`include "memSettings.svh"

module memoryInterfaceTb;

	logic clk;
	logic arstN;
	logic awValid;
	logic awReady;
	memBusPkg::axiAw aw;
	logic wValid;
	logic wReady;
	memBusPkg::axiW w;
	logic bValid;
	logic bReady;
	memBusPkg::axiB b;
	logic arValid;
	logic arReady;
	memBusPkg::axiAr ar;
	logic rValid;
	logic rReady;
	memBusPkg::axiR r;

	// one entry per data line of the stimulus file
	bit                         stimIsWrite [$];
	logic [`AXI_ADDR_WIDTH-1:0] stimAddr [$];
	logic [`AXI_DATA_WIDTH-1:0] stimData [$];
	logic [3:0]                 stimStrb [$];
	logic [1:0]                 stimResp [$];
	logic [`AXI_DATA_WIDTH-1:0] stimRdata [$];

	// accepted requests still owed a response, oldest first, with the edge that took them
	int pendIdx [$];
	int pendEdge [$];

	int edgeCount = 0;
	int cycleLimit = 50;

	memoryInterface u_dut (
		.clk(clk), .arstN(arstN),
		.awValid(awValid), .awReady(awReady), .aw(aw),
		.wValid(wValid), .wReady(wReady), .w(w),
		.bValid(bValid), .bReady(bReady), .b(b),
		.arValid(arValid), .arReady(arReady), .ar(ar),
		.rValid(rValid), .rReady(rReady), .r(r)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// counts rising edges, the latency check reads it too
	always @(posedge clk) begin
		edgeCount = edgeCount + 1;
		if (edgeCount > cycleLimit) begin
			$display("timeout after %0d cycles, the run did not finish its transactions",
				edgeCount);
			stopOnFailure();
		end
	end

	task automatic stopOnFailure();
		$display("Regression failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error %s actual 0x%08h expected 0x%08h", name, actual, expected);
			stopOnFailure();
		end
	endtask

	task automatic readStimulus();
		int fd;
		int code;
		string line;
		logic [31:0] fOp;
		logic [31:0] fAddr;
		logic [31:0] fData;
		logic [31:0] fStrb;
		logic [31:0] fResp;
		logic [31:0] fRdata;
		fd = $fopen("verif/memStimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verif/memStimulus.txt");
			stopOnFailure();
		end else begin
			while ($fgets(line, fd) != 0) begin
				// lines starting with a hash are notes about the columns
				if (line.len() == 0 || line[0] == "#") begin
					continue;
				end
				code = $sscanf(line, "%h %h %h %h %h %h",
					fOp, fAddr, fData, fStrb, fResp, fRdata);
				if (code == 6) begin
					stimIsWrite.push_back(fOp[0]);
					stimAddr.push_back(fAddr);
					stimData.push_back(fData);
					stimStrb.push_back(fStrb[3:0]);
					stimResp.push_back(fResp[1:0]);
					stimRdata.push_back(fRdata);
				end else if (code > 0) begin
					$display("stimulus line has the wrong number of columns: %s", line);
					stopOnFailure();
				end
			end
			$fclose(fd);
		end
	endtask

	// offers one transaction, a write puts AW and W up together
	task automatic presentRequest(input int idx);
		if (stimIsWrite[idx]) begin
			awValid = 1'b1;
			wValid = 1'b1;
			arValid = 1'b0;
			aw.addr = stimAddr[idx];
			// prot is ignored by the memory, vary it anyway
			aw.prot = 3'(idx);
			w.data = stimData[idx];
			w.strb = stimStrb[idx];
		end else begin
			awValid = 1'b0;
			wValid = 1'b0;
			arValid = 1'b1;
			ar.addr = stimAddr[idx];
			ar.prot = 3'(idx);
		end
	endtask

	task automatic idleRequest();
		awValid = 1'b0;
		wValid = 1'b0;
		arValid = 1'b0;
	endtask

	// reports whether the request on offer is taken at the coming rising edge
	task automatic requestAccepted(output bit taken);
		if (awValid && wValid) begin
			checkValue("wReady", 32'(wReady), 32'(awReady));
		end
		taken = (awValid && awReady && wValid && wReady) || (arValid && arReady);
	endtask

	// compares a B or R response with the oldest outstanding request
	task automatic collectResponse(input bit checkLatency);
		int idx;
		if (bValid || rValid) begin
			if (bValid && rValid) begin
				$display("B and R responses were offered in the same cycle");
				stopOnFailure();
			end
			if (pendIdx.size() == 0) begin
				$display("a response arrived with no request outstanding");
				stopOnFailure();
			end
			idx = pendIdx[0];
			// the accepting edge loads the MAR, the next two load the array and the MDR
			if (checkLatency) begin
				checkValue("latency", 32'(edgeCount - pendEdge[0] + 1), 32'd3);
			end
			if (bValid != stimIsWrite[idx]) begin
				$display("response on the wrong channel for transaction %0d", idx);
				stopOnFailure();
			end
			if (bValid && bReady) begin
				checkValue("b.resp", 32'(b.resp), 32'(stimResp[idx]));
				pendIdx.delete(0);
				pendEdge.delete(0);
			end else if (rValid && rReady) begin
				checkValue("r.resp", 32'(r.resp), 32'(stimResp[idx]));
				checkValue("r.data", r.data, stimRdata[idx]);
				pendIdx.delete(0);
				pendEdge.delete(0);
			end
		end
	endtask

	// drives on the falling edge and samples one step later, well before the rising edge
	task automatic runPass(input bit backToBack);
		int next;
		bit taken;
		next = 0;
		while (next < stimIsWrite.size() || pendIdx.size() > 0) begin
			@(negedge clk);
			if (backToBack) begin
				bReady = ($urandom % 4) != 0;
				rReady = ($urandom % 4) != 0;
			end else begin
				bReady = 1'b1;
				rReady = 1'b1;
			end
			// single mode waits for each response before the next request
			if (next < stimIsWrite.size() && (backToBack || pendIdx.size() == 0)) begin
				presentRequest(next);
			end else begin
				idleRequest();
			end
			#1;
			collectResponse(!backToBack);
			requestAccepted(taken);
			if (taken) begin
				pendIdx.push_back(next);
				pendEdge.push_back(edgeCount + 1);
				next++;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h6267_89da));
		arstN = 1'b0;
		awValid = 1'b0;
		aw = '0;
		wValid = 1'b0;
		w = '0;
		bReady = 1'b1;
		arValid = 1'b0;
		ar = '0;
		rReady = 1'b1;
		readStimulus();
		if (stimIsWrite.size() == 0) begin
			$display("the stimulus file holds no transactions");
			stopOnFailure();
		end
		// the file is replayed twice, 20 cycles per line is far above the worst case
		cycleLimit = 20 * 2 * stimIsWrite.size() + 50;
		repeat (2) @(posedge clk);
		@(negedge clk);
		// nothing is offered or answered while held in reset
		checkValue("awReady", 32'(awReady), 32'd0);
		checkValue("wReady", 32'(wReady), 32'd0);
		checkValue("arReady", 32'(arReady), 32'd0);
		checkValue("bValid", 32'(bValid), 32'd0);
		checkValue("rValid", 32'(rValid), 32'd0);
		arstN = 1'b1;
		// first pass is one request at a time with B and R always ready
		runPass(1'b0);
		// second pass issues back to back while B and R ready drop at random
		runPass(1'b1);
		// a response after the last one would be a duplicate
		repeat (5) begin
			@(negedge clk);
			idleRequest();
			bReady = 1'b1;
			rReady = 1'b1;
			#1;
			if (bValid || rValid) begin
				$display("a response appeared after every request had been answered");
				stopOnFailure();
			end
		end
		$display("Regression passed");
		$finish;
	end

endmodule
